//--- source/tft_spi_pkg.sv
`default_nettype none

package tft_spi_pkg;

    // one frame word, seen either as a raw shift word or as cycle/payload
    typedef union packed {
        logic [15:0] raw;
        struct packed {
            logic [7:0] cycle;   // sent first
            logic [7:0] payload;
        } fields;
    } tft_frame_t;

    // RA8875 cycle codes, upper byte of the frame
    localparam logic [7:0] cyc_cmd_write   = 8'h80;
    localparam logic [7:0] cyc_data_write  = 8'h00;
    localparam logic [7:0] cyc_data_read   = 8'h40;
    localparam logic [7:0] cyc_status_read = 8'hC0;

    // clk cycles per half sclk period
    localparam int clk_div_default = 2;

    localparam int frame_bits = 16;

endpackage

`default_nettype wire

//--- source/tft_spi_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module tft_spi_fsm import tft_spi_pkg::*; (
    input  wire        clk,
    input  wire        nrst,
    input  wire        wi,
    input  wire        delay,
    input  tft_frame_t in,
    input  wire        fall_tick,
    input  wire        bit_last,

    output logic       run,
    output logic       load,
    output logic       shift_en,
    output logic       capture_en,
    output logic       update,
    output logic       busy,
    output logic       done,
    output logic       chip_select
);

    typedef enum logic [1:0] {
        st_idle   = 2'd0,
        st_load   = 2'd1,
        st_output = 2'd2,
        st_finish = 2'd3
    } state_t;

    state_t state, next_state;
    logic   read_q, read_d;
    logic   frame_end;

    // sclk falling at the end of bit 15
    assign frame_end = (state == st_output) && fall_tick && bit_last;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            state  <= st_idle;
            read_q <= 1'b0;
            done   <= 1'b0;
        end else begin
            state  <= next_state;
            read_q <= read_d;
            done   <= frame_end; // high for the first finish cycle only
        end
    end

    // frame kind, decoded while the shifter loads
    always_comb begin
        read_d = read_q;
        if (state == st_load) begin
            case (in.fields.cycle)
                cyc_data_read: read_d = 1'b1;
                default:       read_d = 1'b0; // writes and status reads keep nothing
            endcase
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            st_idle: begin
                if (wi && !delay) begin
                    next_state = st_load;
                end
            end
            st_load: begin
                next_state = st_output;
            end
            st_output: begin
                if (frame_end) begin
                    next_state = st_finish;
                end
            end
            st_finish: begin
                // held request gives a single frame
                if (!wi) begin
                    next_state = st_idle;
                end
            end
            default: begin
                next_state = st_idle;
            end
        endcase
    end

    assign run         = (state == st_output);
    assign load        = (state == st_load);
    assign shift_en    = (state == st_output);
    assign capture_en  = (state == st_output) && read_q;
    assign update      = frame_end && read_q; // miso_out changes at the finish edge
    assign busy        = (state == st_load) || (state == st_output);
    assign chip_select = !busy;

endmodule

`default_nettype wire

//--- source/tft_spi_timer.sv
`timescale 1ns/1ps
`default_nettype none

module tft_spi_timer import tft_spi_pkg::*; #(
    parameter int clk_div = clk_div_default
) (
    input  wire  clk,
    input  wire  nrst,
    input  wire  run,

    output logic sclk,
    output logic rise_tick,
    output logic fall_tick,
    output logic bit_last
);

    localparam int               cnt_w    = (clk_div > 1) ? $clog2(clk_div) : 1;
    localparam logic [cnt_w-1:0] cnt_top  = cnt_w'(clk_div - 1);
    localparam logic [4:0]       last_bit = 5'(frame_bits - 1);

    logic [cnt_w-1:0] div_cnt;
    logic             sclk_q;
    logic [4:0]       bit_cnt;
    logic             half_end;

    // last clk cycle of each sclk half period
    assign half_end  = run && (div_cnt == cnt_top);
    assign rise_tick = half_end && !sclk_q;
    assign fall_tick = half_end && sclk_q;
    assign bit_last  = (bit_cnt == last_bit);
    assign sclk      = sclk_q;

    always_ff @(posedge clk) begin
        if (!nrst) begin
            div_cnt <= '0;
            sclk_q  <= 1'b0;
            bit_cnt <= '0;
        end else if (!run) begin
            // idle between frames, sclk parked low
            div_cnt <= '0;
            sclk_q  <= 1'b0;
            bit_cnt <= '0;
        end else begin
            if (half_end) begin
                div_cnt <= '0;
                sclk_q  <= !sclk_q;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            if (fall_tick) begin
                bit_cnt <= bit_cnt + 5'd1; // wraps past 15 only as run drops
            end
        end
    end

endmodule

`default_nettype wire

//--- source/tft_spi_shifter.sv
`timescale 1ns/1ps
`default_nettype none

module tft_spi_shifter import tft_spi_pkg::*; (
    input  wire        clk,
    input  wire        nrst,
    input  tft_frame_t in,
    input  wire        miso_in,
    input  wire        load,
    input  wire        shift_en,
    input  wire        capture_en,
    input  wire        update,
    input  wire        rise_tick,
    input  wire        fall_tick,

    output logic       bit_data,
    output logic [7:0] miso_out
);

    tft_frame_t tx_q;
    logic [7:0] rx_q;

    // transmit side, msb first
    always_ff @(posedge clk) begin
        if (!nrst) begin
            tx_q.raw <= '0;
        end else if (load) begin
            tx_q.raw <= in.raw;
        end else if (shift_en && fall_tick) begin
            tx_q.raw <= {tx_q.raw[14:0], 1'b0}; // next bit out as sclk drops
        end
    end

    assign bit_data = tx_q.raw[15];

    // receive side
    // 16 samples per frame, only the final 8 survive
    always_ff @(posedge clk) begin
        if (capture_en && rise_tick) begin
            rx_q <= {rx_q[6:0], miso_in};
        end
    end

    always_ff @(posedge clk) begin
        if (!nrst) begin
            miso_out <= '0;
        end else if (update) begin
            miso_out <= rx_q; // held until the next read frame
        end
    end

endmodule

`default_nettype wire

//--- source/tft_spi_top.sv
`timescale 1ns/1ps
`default_nettype none

module tft_spi_top import tft_spi_pkg::*; #(
    parameter int clk_div = clk_div_default
) (
    input  wire        clk,
    input  wire        nrst,
    input  tft_frame_t in,
    input  wire        wi,
    input  wire        delay,
    input  wire        miso_in,

    output logic [7:0] miso_out,
    output logic       busy,
    output logic       done,
    output logic       chip_select,
    output logic       bit_data,
    output logic       sclk
);

    logic run;
    logic rise_tick;
    logic fall_tick;
    logic bit_last;
    logic load;
    logic shift_en;
    logic capture_en;
    logic update;

    tft_spi_fsm fsm_i (
        .clk         (clk),
        .nrst        (nrst),
        .wi          (wi),
        .delay       (delay),
        .in          (in),
        .fall_tick   (fall_tick),
        .bit_last    (bit_last),
        .run         (run),
        .load        (load),
        .shift_en    (shift_en),
        .capture_en  (capture_en),
        .update      (update),
        .busy        (busy),
        .done        (done),
        .chip_select (chip_select)
    );

    tft_spi_timer #(
        .clk_div (clk_div)
    ) timer_i (
        .clk       (clk),
        .nrst      (nrst),
        .run       (run),
        .sclk      (sclk),
        .rise_tick (rise_tick),
        .fall_tick (fall_tick),
        .bit_last  (bit_last)
    );

    tft_spi_shifter shifter_i (
        .clk        (clk),
        .nrst       (nrst),
        .in         (in),
        .miso_in    (miso_in),
        .load       (load),
        .shift_en   (shift_en),
        .capture_en (capture_en),
        .update     (update),
        .rise_tick  (rise_tick),
        .fall_tick  (fall_tick),
        .bit_data   (bit_data),
        .miso_out   (miso_out)
    );

endmodule

`default_nettype wire

//--- verif/ra8875_spi_model.sv
`timescale 1ns/1ps
`default_nettype none

module ra8875_spi_model import tft_spi_pkg::*; (
    input  wire         chip_select,
    input  wire         sclk,
    input  wire         bit_data,
    input  wire  [7:0]  read_byte,

    output logic        miso_in,
    output int          frame_count,
    output logic [15:0] last_frame,
    output int          last_bits
);

    logic [15:0] rx_word   = '0;
    logic [15:0] tx_word   = '0;
    int          bit_count = 0;
    int          frames    = 0;
    logic [15:0] frame_q   = '0;
    int          bits_q    = 0;
    logic        cs_prev   = 1'b1;
    logic        sclk_prev = 1'b0;
    logic        miso_q    = 1'b0;

    assign miso_in     = miso_q;
    assign frame_count = frames;
    assign last_frame  = frame_q;
    assign last_bits   = bits_q;

    // spi mode 0 slave, samples on rising sclk and drives on falling sclk
    always @(posedge chip_select or negedge chip_select or posedge sclk or negedge sclk) begin
        if (chip_select !== cs_prev) begin
            if (chip_select === 1'b0) begin
                tx_word   = {8'h00, read_byte}; // returned byte sits in the low half
                rx_word   = '0;
                bit_count = 0;
            end else if (cs_prev === 1'b0) begin
                frames  = frames + 1;
                frame_q = rx_word;
                bits_q  = bit_count;
            end
        end else if (sclk !== sclk_prev && chip_select === 1'b0) begin
            if (sclk) begin
                rx_word   = {rx_word[14:0], bit_data};
                bit_count = bit_count + 1;
            end else begin
                tx_word = {tx_word[14:0], 1'b0};
            end
        end
        cs_prev   = chip_select;
        sclk_prev = sclk;
        miso_q    = (chip_select === 1'b0) ? tx_word[15] : 1'b0;
    end

endmodule

`default_nettype wire

//--- verif/tft_spi_tb.sv
`timescale 1ns/1ps
`default_nettype none

module tft_spi_tb import tft_spi_pkg::*; ();

    localparam int clk_div        = 2;
    localparam int num_rows       = 10;
    localparam int reset_cycles   = 5;
    localparam int frame_cycles   = 32 * clk_div + 2; // accept edge to done
    localparam int wi_hold_cycles = 20;

    typedef struct packed {
        logic [7:0] cycle;
        logic [7:0] payload;
        logic [7:0] ret_byte; // byte the display hands back
        logic [3:0] hold;     // cycles of delay before the request
    } row_t;

    row_t rows [num_rows] = '{
        '{cyc_cmd_write,   8'h01, 8'h00, 4'd0},
        '{cyc_data_write,  8'hA5, 8'h00, 4'd3},
        '{cyc_data_read,   8'h00, 8'h3C, 4'd0},
        '{cyc_status_read, 8'h00, 8'hE7, 4'd2},
        '{cyc_cmd_write,   8'h8E, 8'h55, 4'd5},
        '{cyc_data_read,   8'hFF, 8'hC9, 4'd1},
        '{cyc_data_write,  8'h5A, 8'h12, 4'd0},
        '{cyc_data_read,   8'h7F, 8'h81, 4'd4},
        '{cyc_status_read, 8'h00, 8'h00, 4'd0},
        '{cyc_data_read,   8'h00, 8'h00, 4'd0}
    };

    logic        clk = 1'b0;
    logic        nrst;
    logic        wi;
    logic        delay;
    tft_frame_t  in_frame;
    logic        miso_in;
    logic [7:0]  read_byte;
    logic [7:0]  miso_out;
    logic        busy;
    logic        done;
    logic        chip_select;
    logic        bit_data;
    logic        sclk;
    int          frame_count;
    logic [15:0] last_frame;
    int          last_bits;
    logic [7:0]  exp_miso;
    int          cycle_cnt   = 0;
    int          cycle_limit;

    tft_spi_top #(
        .clk_div (clk_div)
    ) dut_i (
        .clk         (clk),
        .nrst        (nrst),
        .in          (in_frame),
        .wi          (wi),
        .delay       (delay),
        .miso_in     (miso_in),
        .miso_out    (miso_out),
        .busy        (busy),
        .done        (done),
        .chip_select (chip_select),
        .bit_data    (bit_data),
        .sclk        (sclk)
    );

    ra8875_spi_model model_i (
        .chip_select (chip_select),
        .sclk        (sclk),
        .bit_data    (bit_data),
        .read_byte   (read_byte),
        .miso_in     (miso_in),
        .frame_count (frame_count),
        .last_frame  (last_frame),
        .last_bits   (last_bits)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            $display("timeout: no result after %0d clock cycles", cycle_limit);
            $display(">>> FAIL");
            $fatal(1, "simulation ran past its cycle limit");
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected 0x%0h, got 0x%0h",
                     $time, name, expected, actual);
            $display(">>> FAIL");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic int largest_hold();
        int m;
        m = 0;
        for (int i = 0; i < num_rows; i++) begin
            if (int'(rows[i].hold) > m) begin
                m = int'(rows[i].hold);
            end
        end
        return m;
    endfunction

    task automatic run_row(input int idx);
        tft_frame_t frame;
        int         waited;
        frame.fields.cycle   = rows[idx].cycle;
        frame.fields.payload = rows[idx].payload;
        @(negedge clk);
        in_frame  = frame;
        read_byte = rows[idx].ret_byte;
        wi        = 1'b1;
        delay     = (rows[idx].hold != 4'd0);
        // request pending but held off
        repeat (rows[idx].hold) begin
            @(negedge clk);
            check_value("chip_select in hold-off", 32'(chip_select), 32'd1);
            check_value("busy in hold-off", 32'(busy), 32'd0);
        end
        delay  = 1'b0;
        waited = 0;
        while (!done && waited <= frame_cycles) begin
            @(negedge clk);
            waited = waited + 1;
            if (!done && waited < frame_cycles) begin
                check_value("busy in frame", 32'(busy), 32'd1);
                check_value("chip_select in frame", 32'(chip_select), 32'd0);
            end
        end
        check_value("done latency", waited, frame_cycles);
        check_value("busy at done", 32'(busy), 32'd0);
        check_value("chip_select at done", 32'(chip_select), 32'd1);
        check_value("sclk at done", 32'(sclk), 32'd0);
        if (frame.fields.cycle == cyc_data_read) begin
            exp_miso = rows[idx].ret_byte;
        end
        check_value("miso_out", 32'(miso_out), 32'(exp_miso));
        // wi still high, no second frame may start
        repeat (wi_hold_cycles) begin
            @(negedge clk);
            check_value("chip_select after done", 32'(chip_select), 32'd1);
            check_value("busy after done", 32'(busy), 32'd0);
            check_value("done after done", 32'(done), 32'd0);
        end
        wi = 1'b0;
        check_value("frame_count", frame_count, idx + 1);
        check_value("frame word", 32'(last_frame), 32'(frame.raw));
        check_value("frame bits", last_bits, frame_bits);
    endtask

    initial begin
        nrst      = 1'b0;
        wi        = 1'b0;
        delay     = 1'b0;
        in_frame  = '0;
        read_byte = 8'h00;
        exp_miso  = 8'h00;
        cycle_limit = reset_cycles + 10
                    + num_rows * (32 * clk_div + 10 + largest_hold() + wi_hold_cycles);
        repeat (reset_cycles) @(negedge clk);
        nrst = 1'b1;
        @(negedge clk);
        check_value("chip_select after reset", 32'(chip_select), 32'd1);
        check_value("sclk after reset", 32'(sclk), 32'd0);
        check_value("bit_data after reset", 32'(bit_data), 32'd0);
        check_value("busy after reset", 32'(busy), 32'd0);
        check_value("done after reset", 32'(done), 32'd0);
        check_value("miso_out after reset", 32'(miso_out), 32'd0);
        for (int r = 0; r < num_rows; r++) begin
            run_row(r);
        end
        repeat (4) @(negedge clk);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

//--- build.f
source/tft_spi_pkg.sv
source/tft_spi_fsm.sv
source/tft_spi_timer.sv
source/tft_spi_shifter.sv
source/tft_spi_top.sv
verif/ra8875_spi_model.sv
verif/tft_spi_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the tft spi testbench with verilator
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=tft_spi_sim
log_file=sim.log

verilator --binary --timing -f build.f --top-module tft_spi_tb \
    -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the log decides the result
grep -q -x -F ">>> PASS" "$log_file"
if [ $? -ne 0 ]; then
    echo "pass message not found in $log_file"
    exit 1
fi

echo "simulation passed"
exit 0
